// ==== all.f ====
src/eth_pkg.sv
src/crc32_d8.sv
src/byte_fifo.sv
src/gmii_tx.sv
src/gmii_rx.sv
src/eth_gmii_mac.sv
tb/eth_gmii_mac_sva.sv
tb/tb_eth_gmii_mac.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_eth_gmii_mac -Mdir obj_dir

run: compile
	-./obj_dir/Vtb_eth_gmii_mac +verilator+error+limit+100 > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_eth_gmii_mac.sv ====
`default_nettype none

module tb_eth_gmii_mac;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic reset;
	eth_pkg::eth_tx_req_t tx_req;
	eth_pkg::gmii_rx_t gmii_in;
	logic tx_busy;
	eth_pkg::gmii_tx_t gmii_out;
	eth_pkg::eth_rx_out_t rx_out;
	logic [15:0] err_count;
	logic [15:0] lfsr;
	int n;

	eth_gmii_mac DUT (.*);

	bind eth_gmii_mac eth_gmii_mac_sva u_sva (
		.clk(clk), .reset(reset), .tx_req(tx_req), .tx_busy(tx_busy),
		.gmii_out(gmii_out), .rx_out(rx_out), .err_count(err_count)
	);

	// gmii loopback
	assign gmii_in.dv = gmii_out.en;
	assign gmii_in.er = gmii_out.er;
	assign gmii_in.d = gmii_out.d;

	always #5 clk = ~clk;

	task automatic fail_run(input string why);
		$display("sim failed");
		$fatal(1, "%s", why);
	endtask

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [63:0] rand_bits(input int k);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < k; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic send_frame(input int len);
		eth_pkg::eth_head_u h;
		h.fields.dmac = 48'(rand_bits(48));
		h.fields.smac = 48'(rand_bits(48));
		h.fields.ethertype = 16'(rand_bits(16));
		@(posedge clk);
		tx_req.head <= h;
		for (int i = 0; i < len; i++) begin
			tx_req.dven <= 1'b1;
			tx_req.data <= 8'(rand_bits(8));
			@(posedge clk);
		end
		tx_req.dven <= 1'b0;
	endtask

	task automatic wait_frame_done();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (t > 1000)
				fail_run("timeout waiting for rx_out.frame_done");
		end while (!rx_out.frame_done);
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (t > 1000)
				fail_run("timeout waiting for tx_busy to fall");
		end while (tx_busy);
	endtask

	always @(negedge clk)
		if (DUT.u_sva.fails != 0)
			fail_run("an assertion in the bound checker failed");

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		tx_req = '0;
		lfsr = 16'd41913;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (int f = 0; f < 6; f++) begin
			if (f % 2 == 0)
				n = 1 + int'(rand_bits(6)) % 45; // padded
			else
				n = 46 + int'(rand_bits(6)) % 35;
			send_frame(n);
			wait_frame_done();
			if (f == 5) begin
				// start attempt inside the gap
				@(posedge clk);
				tx_req.dven <= 1'b1;
				@(posedge clk);
				tx_req.dven <= 1'b0;
			end
			wait_idle();
		end
		repeat (4) @(negedge clk);
		if (DUT.u_sva.fails != 0) begin
			fail_run("an assertion in the bound checker failed");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb/eth_gmii_mac_sva.sv ====
`default_nettype none

module eth_gmii_mac_sva (
	input logic                 clk,
	input logic                 reset,
	input eth_pkg::eth_tx_req_t tx_req,
	input logic                 tx_busy,
	input eth_pkg::gmii_tx_t    gmii_out,
	input eth_pkg::eth_rx_out_t rx_out,
	input logic [15:0]          err_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic dven_d;
	logic accept;
	logic collide;
	logic capture; // inside an accepted dven burst
	eth_pkg::eth_head_u head_q;
	logic [7:0] pay [0:2047];
	int n_sent;
	int plen;
	int tpos; // byte index while en is high
	int low_cnt;
	int rcnt;
	int rh; // header bytes delivered on rx
	int hidx;
	int pidx;
	logic [7:0] exp_d;
	logic [7:0] exp_rx;
	logic [7:0] exp_hd;
	int fails = 0;

	assign accept = tx_req.dven & ~dven_d & ~tx_busy;
	assign collide = tx_req.dven & ~dven_d & tx_busy;
	assign plen = (n_sent < eth_pkg::payload_min) ? eth_pkg::payload_min : n_sent;
	assign exp_rx = pay[rcnt];
	assign exp_hd = head_q.raw[8 * (eth_pkg::head_len - 1 - rh) +: 8];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			dven_d <= 1'b0;
			capture <= 1'b0;
			n_sent <= 0;
			tpos <= 0;
			low_cnt <= 255;
			rcnt <= 0;
			rh <= 0;
		end else begin
			dven_d <= tx_req.dven;
			if (accept) begin
				capture <= 1'b1;
				n_sent <= 1;
			end else if (capture && tx_req.dven) begin
				n_sent <= n_sent + 1;
			end else begin
				capture <= 1'b0;
			end
			tpos <= gmii_out.en ? tpos + 1 : 0;
			if (gmii_out.en)
				low_cnt <= 0;
			else if (low_cnt < 255)
				low_cnt <= low_cnt + 1;
			rcnt <= rx_out.head_done ? 0 : rcnt + int'(rx_out.dven);
			rh <= rx_out.head_done ? 0 : rh + int'(rx_out.hden);
		end
	end

	// user side record of header and payload
	always_ff @(posedge clk) begin
		if (accept) begin
			head_q <= tx_req.head;
			pay[0] <= tx_req.data;
		end else if (capture && tx_req.dven) begin
			pay[n_sent] <= tx_req.data;
		end
	end

	// expected wire byte at position tpos
	always_comb begin
		hidx = tpos - (eth_pkg::preamble_len + 1);
		pidx = hidx - eth_pkg::head_len;
		if (tpos < eth_pkg::preamble_len)
			exp_d = 8'h55;
		else if (hidx < 0)
			exp_d = 8'hd5;
		else if (pidx < 0)
			exp_d = head_q.raw[8 * (eth_pkg::head_len - 1 - hidx) +: 8]; // msb first
		else if (pidx < n_sent)
			exp_d = pay[pidx];
		else
			exp_d = 8'h00; // padding
	end

	a_start: assert property (@(posedge clk) disable iff (reset)
		$rose(gmii_out.en) == $past(accept))
	else begin
		fails++;
		$error("error gmii_out.en rise=%h expected %h", $rose(gmii_out.en), $past(accept));
	end

	a_data: assert property (@(posedge clk) disable iff (reset)
		gmii_out.en && pidx < plen |-> gmii_out.d == exp_d)
	else begin
		fails++;
		$error("error gmii_out.d=%h expected %h at byte %0d", $sampled(gmii_out.d),
			$sampled(exp_d), $sampled(tpos));
	end

	a_len: assert property (@(posedge clk) disable iff (reset)
		$fell(gmii_out.en) |-> pidx == plen + eth_pkg::fcs_len)
	else begin
		fails++;
		$error("error gmii_out.en length=%h expected %h", $sampled(tpos),
			$sampled(plen) + 26);
	end

	// busy covers the frame and the whole gap
	a_busy: assert property (@(posedge clk) disable iff (reset)
		tx_busy == (gmii_out.en || low_cnt < eth_pkg::ifg_len))
	else begin
		fails++;
		$error("error tx_busy=%h with %0d idle cycles", $sampled(tx_busy), $sampled(low_cnt));
	end

	a_rx_hbyte: assert property (@(posedge clk) disable iff (reset)
		rx_out.hden |-> rh < eth_pkg::head_len && rx_out.data == exp_hd)
	else begin
		fails++;
		$error("error rx_out.data=%h expected header byte %h at %0d",
			$sampled(rx_out.data), $sampled(exp_hd), $sampled(rh));
	end

	a_head: assert property (@(posedge clk) disable iff (reset)
		rx_out.head_done |-> rx_out.hden && rh == eth_pkg::head_len - 1 &&
			rx_out.head.fields == head_q.fields)
	else begin
		fails++;
		$error("error rx_out.head=%h expected %h after %0d header bytes",
			$sampled(rx_out.head.raw), $sampled(head_q.raw), $sampled(rh));
	end

	a_rx_data: assert property (@(posedge clk) disable iff (reset)
		rx_out.dven && rcnt < n_sent |-> rx_out.data == exp_rx)
	else begin
		fails++;
		$error("error rx_out.data=%h expected %h", $sampled(rx_out.data), $sampled(exp_rx));
	end

	a_rx_err: assert property (@(posedge clk) disable iff (reset)
		!rx_out.err)
	else begin
		fails++;
		$error("error rx_out.err=%h expected 0", $sampled(rx_out.err));
	end

	a_done: assert property (@(posedge clk) disable iff (reset)
		rx_out.frame_done |-> rx_out.crc_ok && rcnt == plen)
	else begin
		fails++;
		$error("error rx_out.crc_ok=%h rx bytes=%h expected %h", $sampled(rx_out.crc_ok),
			$sampled(rcnt), $sampled(plen));
	end

	a_err: assert property (@(posedge clk) disable iff (reset)
		err_count == $past(err_count) + {15'h0000, $past(collide)})
	else begin
		fails++;
		$error("error err_count=%h previous %h", $sampled(err_count), $past(err_count));
	end

endmodule

`default_nettype wire

// ==== src/eth_gmii_mac.sv ====
`default_nettype none

module eth_gmii_mac (
	input  logic                 clk,
	input  logic                 reset,
	input  eth_pkg::eth_tx_req_t tx_req,
	input  eth_pkg::gmii_rx_t    gmii_in,
	output logic                 tx_busy,
	output eth_pkg::gmii_tx_t    gmii_out,
	output eth_pkg::eth_rx_out_t rx_out,
	output logic [15:0]          err_count
);

	logic [7:0] fifo_rdata;
	logic fifo_ren;
	logic fifo_empty;
	logic fifo_full;
	logic tx_crc_clear;
	logic tx_crc_en;
	logic [31:0] tx_crc;
	logic start_collision;
	logic rx_crc_clear;
	logic rx_crc_en;
	logic [7:0] rx_crc_d;
	logic rx_residue_ok;
	logic byte_error;
	logic [1:0] err_inc;
	logic [16:0] err_sum;

	byte_fifo u_fifo (
		.clk(clk),
		.reset(reset),
		.wen(tx_req.dven),
		.wdata(tx_req.data),
		.ren(fifo_ren),
		.rdata(fifo_rdata),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	gmii_tx u_tx (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.fifo_rdata(fifo_rdata),
		.fifo_empty(fifo_empty),
		.crc(tx_crc),
		.fifo_ren(fifo_ren),
		.crc_clear(tx_crc_clear),
		.crc_en(tx_crc_en),
		.gmii_out(gmii_out),
		.busy(tx_busy),
		.start_collision(start_collision)
	);

	// tx crc runs over the bytes as they leave
	crc32_d8 u_tx_crc (
		.clk(clk),
		.reset(reset),
		.clear(tx_crc_clear),
		.en(tx_crc_en),
		.d(gmii_out.d),
		.crc(tx_crc),
		.residue_ok()
	);

	gmii_rx u_rx (
		.clk(clk),
		.reset(reset),
		.gmii_in(gmii_in),
		.residue_ok(rx_residue_ok),
		.crc_clear(rx_crc_clear),
		.crc_en(rx_crc_en),
		.crc_d(rx_crc_d),
		.rx_out(rx_out),
		.byte_error(byte_error)
	);

	crc32_d8 u_rx_crc (
		.clk(clk),
		.reset(reset),
		.clear(rx_crc_clear),
		.en(rx_crc_en),
		.d(rx_crc_d),
		.crc(),
		.residue_ok(rx_residue_ok)
	);

	assign err_inc = {1'b0, start_collision} + {1'b0, tx_req.dven & fifo_full}
		+ {1'b0, byte_error};
	assign err_sum = {1'b0, err_count} + {15'h0000, err_inc};

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			err_count <= '0;
		else
			err_count <= err_sum[16] ? 16'hffff : err_sum[15:0]; // saturate
	end

endmodule

`default_nettype wire

// ==== src/gmii_rx.sv ====
`default_nettype none

module gmii_rx (
	input  logic                 clk,
	input  logic                 reset,
	input  eth_pkg::gmii_rx_t    gmii_in,
	input  logic                 residue_ok,
	output logic                 crc_clear,
	output logic                 crc_en,
	output logic [7:0]           crc_d,
	output eth_pkg::eth_rx_out_t rx_out,
	output logic                 byte_error
);

	eth_pkg::gmii_rx_t in_r;
	logic [1:0] st;
	logic [3:0] cnt; // header byte index
	logic [2:0] fill; // bytes held in the fcs delay line
	logic [31:0] dl;
	logic hbyte;
	logic pbyte;
	logic frame_end;
	logic hden_r;
	logic dven_r;
	logic err_r;
	logic head_done_r;
	logic frame_done_r;
	logic crc_ok_r;
	logic [7:0] data_r;
	eth_pkg::eth_head_u head_r;

	assign hbyte = (st == eth_pkg::rx_head) & in_r.dv;
	assign pbyte = (st == eth_pkg::rx_pay) & in_r.dv;
	assign frame_end = ((st == eth_pkg::rx_head) | (st == eth_pkg::rx_pay)) & ~in_r.dv;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			in_r <= '0;
			st <= eth_pkg::rx_idle;
			cnt <= '0;
			fill <= '0;
			hden_r <= 1'b0;
			dven_r <= 1'b0;
			err_r <= 1'b0;
			head_done_r <= 1'b0;
			frame_done_r <= 1'b0;
			crc_ok_r <= 1'b0;
		end else begin
			in_r <= gmii_in;
			hden_r <= hbyte;
			dven_r <= pbyte & (fill == 3'd4); // byte already followed by four more
			head_done_r <= hbyte & (cnt == eth_pkg::head_len - 1);
			frame_done_r <= frame_end;
			if (frame_end)
				crc_ok_r <= residue_ok;
			if ((hbyte | pbyte) & in_r.er)
				err_r <= 1'b1;
			case (st)
				eth_pkg::rx_idle:
					if (in_r.dv && in_r.d == eth_pkg::sfd_byte) begin
						st <= eth_pkg::rx_head;
						cnt <= '0;
						fill <= '0;
						err_r <= 1'b0;
					end
				eth_pkg::rx_head:
					if (!in_r.dv) begin
						st <= eth_pkg::rx_idle; // runt
					end else begin
						cnt <= cnt + 1'b1;
						if (cnt == eth_pkg::head_len - 1)
							st <= eth_pkg::rx_pay;
					end
				eth_pkg::rx_pay:
					if (!in_r.dv)
						st <= eth_pkg::rx_idle;
					else if (fill != 3'd4)
						fill <= fill + 1'b1;
				default:
					st <= eth_pkg::rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hbyte)
			head_r.raw <= {head_r.raw[eth_pkg::head_len*8-9:0], in_r.d};
		if (pbyte)
			dl <= {dl[23:0], in_r.d};
		data_r <= (st == eth_pkg::rx_head) ? in_r.d : dl[31:24];
	end

	// crc sees header, payload and fcs
	assign crc_clear = (st == eth_pkg::rx_idle);
	assign crc_en = hbyte | pbyte;
	assign crc_d = in_r.d;
	assign byte_error = in_r.dv & in_r.er;

	assign rx_out.hden = hden_r;
	assign rx_out.dven = dven_r;
	assign rx_out.data = data_r;
	assign rx_out.err = err_r;
	assign rx_out.head = head_r;
	assign rx_out.head_done = head_done_r;
	assign rx_out.frame_done = frame_done_r;
	assign rx_out.crc_ok = crc_ok_r;

endmodule

`default_nettype wire

// ==== src/gmii_tx.sv ====
`default_nettype none

module gmii_tx (
	input  logic                 clk,
	input  logic                 reset,
	input  eth_pkg::eth_tx_req_t tx_req,
	input  logic [7:0]           fifo_rdata,
	input  logic                 fifo_empty,
	input  logic [31:0]          crc,
	output logic                 fifo_ren,
	output logic                 crc_clear,
	output logic                 crc_en,
	output eth_pkg::gmii_tx_t    gmii_out,
	output logic                 busy,
	output logic                 start_collision
);

	logic [2:0] st;
	logic [2:0] st_next;
	logic [10:0] cnt;
	logic dven_d;
	logic start;
	logic rd_valid; // fifo_rdata holds a popped byte
	logic [eth_pkg::head_len*8-1:0] head_sr;
	logic [7:0] tx_byte;

	assign start = tx_req.dven & ~dven_d;
	assign busy = (st != eth_pkg::tx_idle);
	assign start_collision = start & busy;

	// pop one ahead so the first payload byte is ready right after the header
	always_comb begin
		case (st)
			eth_pkg::tx_head: fifo_ren = (cnt == eth_pkg::head_len - 1) & ~fifo_empty;
			eth_pkg::tx_pay:  fifo_ren = rd_valid & ~fifo_empty;
			default:          fifo_ren = 1'b0;
		endcase
	end

	always_comb begin
		st_next = st;
		case (st)
			eth_pkg::tx_idle:
				if (start)
					st_next = eth_pkg::tx_pre;
			eth_pkg::tx_pre:
				if (cnt == eth_pkg::preamble_len)
					st_next = eth_pkg::tx_head;
			eth_pkg::tx_head:
				if (cnt == eth_pkg::head_len - 1)
					st_next = eth_pkg::tx_pay;
			eth_pkg::tx_pay:
				// no data coming next cycle and minimum length reached
				if (cnt >= eth_pkg::payload_min - 1 && !fifo_ren)
					st_next = eth_pkg::tx_fcs;
			eth_pkg::tx_fcs:
				if (cnt == eth_pkg::fcs_len - 1)
					st_next = eth_pkg::tx_gap;
			eth_pkg::tx_gap:
				if (cnt == eth_pkg::ifg_len - 1)
					st_next = eth_pkg::tx_idle;
			default:
				st_next = eth_pkg::tx_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			st <= eth_pkg::tx_idle;
			cnt <= '0;
			dven_d <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			st <= st_next;
			if (st_next != st || st == eth_pkg::tx_idle)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			dven_d <= tx_req.dven;
			rd_valid <= fifo_ren;
		end
	end

	// header captured as the preamble starts, then shifted msb first
	always_ff @(posedge clk) begin
		if (st == eth_pkg::tx_idle && start)
			head_sr <= tx_req.head.raw;
		else if (st == eth_pkg::tx_head)
			head_sr <= {head_sr[eth_pkg::head_len*8-9:0], 8'h00};
	end

	always_comb begin
		case (st)
			eth_pkg::tx_pre:
				tx_byte = (cnt == eth_pkg::preamble_len) ? eth_pkg::sfd_byte
					: eth_pkg::preamble_byte;
			eth_pkg::tx_head: tx_byte = head_sr[eth_pkg::head_len*8-1 -: 8];
			eth_pkg::tx_pay:  tx_byte = rd_valid ? fifo_rdata : 8'h00; // zero pad
			eth_pkg::tx_fcs:  tx_byte = crc[{cnt[1:0], 3'b000} +: 8];
			default:          tx_byte = 8'h00;
		endcase
	end

	assign gmii_out.en = busy & (st != eth_pkg::tx_gap);
	assign gmii_out.er = 1'b0;
	assign gmii_out.d = tx_byte;

	assign crc_clear = (st == eth_pkg::tx_pre);
	assign crc_en = (st == eth_pkg::tx_head) | (st == eth_pkg::tx_pay);

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
`default_nettype none

module byte_fifo (
	input  logic       clk,
	input  logic       reset,
	input  logic       wen,
	input  logic [7:0] wdata,
	input  logic       ren,
	output logic [7:0] rdata,
	output logic       empty,
	output logic       full
);

	logic [7:0] mem [0:2**eth_pkg::fifo_aw-1];
	logic [eth_pkg::fifo_aw:0] wptr;
	logic [eth_pkg::fifo_aw:0] rptr;
	logic do_wr;
	logic do_rd;

	// extra msb tells full from empty
	assign empty = (wptr == rptr);
	assign full = (wptr[eth_pkg::fifo_aw] != rptr[eth_pkg::fifo_aw]) &&
		(wptr[eth_pkg::fifo_aw-1:0] == rptr[eth_pkg::fifo_aw-1:0]);

	assign do_wr = wen & ~full; // dropped when full
	assign do_rd = ren & ~empty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (do_wr)
				wptr <= wptr + 1'b1;
			if (do_rd)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wptr[eth_pkg::fifo_aw-1:0]] <= wdata;
		if (do_rd)
			rdata <= mem[rptr[eth_pkg::fifo_aw-1:0]]; // valid next cycle
	end

endmodule

`default_nettype wire

// ==== src/crc32_d8.sv ====
`default_nettype none

module crc32_d8 (
	input  logic        clk,
	input  logic        reset,
	input  logic        clear,
	input  logic        en,
	input  logic [7:0]  d,
	output logic [31:0] crc,
	output logic        residue_ok
);

	logic [31:0] r;

	// one byte through the reflected register, lsb first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] x;
		x = c ^ {24'h000000, b};
		for (int i = 0; i < 8; i++) begin
			x = x[0] ? ((x >> 1) ^ eth_pkg::crc_poly) : (x >> 1);
		end
		return x;
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			r <= '1;
		end else if (clear) begin
			r <= '1;
		end else if (en) begin
			r <= crc_byte(r, d);
		end
	end

	assign crc = ~r; // byte 0 goes on the wire first
	assign residue_ok = (r == eth_pkg::crc_residue);

endmodule

`default_nettype wire

// ==== src/eth_pkg.sv ====
`default_nettype none

package eth_pkg;

	// frame geometry
	localparam int head_len = 14;
	localparam int payload_min = 46;
	localparam int preamble_len = 7;
	localparam int fcs_len = 4;
	localparam int ifg_len = 12;
	localparam int fifo_aw = 5; // 32 entries

	localparam logic [7:0] preamble_byte = 8'h55;
	localparam logic [7:0] sfd_byte = 8'hd5;

	// reflected ieee polynomial and the good-frame remainder
	localparam logic [31:0] crc_poly = 32'hedb88320;
	localparam logic [31:0] crc_residue = 32'hdebb20e3;

	// transmit fsm
	localparam logic [2:0] tx_idle = 3'd0;
	localparam logic [2:0] tx_pre = 3'd1;
	localparam logic [2:0] tx_head = 3'd2;
	localparam logic [2:0] tx_pay = 3'd3;
	localparam logic [2:0] tx_fcs = 3'd4;
	localparam logic [2:0] tx_gap = 3'd5;

	// receive fsm
	localparam logic [1:0] rx_idle = 2'd0; // also the sfd search
	localparam logic [1:0] rx_head = 2'd1;
	localparam logic [1:0] rx_pay = 2'd2;

	typedef struct packed {
		logic [47:0] dmac;
		logic [47:0] smac;
		logic [15:0] ethertype;
	} eth_head_fields_t;

	// framers see a flat word, users see the fields
	typedef union packed {
		logic [head_len*8-1:0] raw;
		eth_head_fields_t fields;
	} eth_head_u;

	typedef struct packed {
		logic dven;
		logic [7:0] data;
		eth_head_u head;
	} eth_tx_req_t;

	typedef struct packed {
		logic hden;
		logic dven;
		logic [7:0] data;
		logic err;
		eth_head_u head;
		logic head_done;
		logic frame_done;
		logic crc_ok;
	} eth_rx_out_t;

	typedef struct packed {
		logic en;
		logic er;
		logic [7:0] d;
	} gmii_tx_t;

	typedef struct packed {
		logic dv;
		logic er;
		logic [7:0] d;
	} gmii_rx_t;

endpackage

`default_nettype wire
